//--- filelist.f
+incdir+src
src/lsuOpPkg.sv
src/lsuBusPkg.sv
src/memReqIf.sv
src/lsuControl.sv
src/clintTimer.sv
src/scratchpadMem.sv
src/axiLiteMaster.sv
src/loadExtend.sv
src/lsuTop.sv
verif/axiDeviceModel.sv
verif/lsuTb.sv

//--- src/axiLiteMaster.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module axiLiteMaster (
    input  logic                   clock,
    input  logic                   reset,
    memReqIf.target                bus,
    output logic                   arValid,
    input  logic                   arReady,
    output logic [`LSU_ADDR_W-1:0] arAddr,
    input  logic                   rValid,
    output logic                   rReady,
    input  logic [`LSU_DATA_W-1:0] rData,
    input  logic [1:0]             rResp,
    output logic                   awValid,
    input  logic                   awReady,
    output logic [`LSU_ADDR_W-1:0] awAddr,
    output logic                   wValid,
    input  logic                   wReady,
    output logic [`LSU_DATA_W-1:0] wData,
    output logic [`LSU_MASK_W-1:0] wStrb,
    input  logic                   bValid,
    output logic                   bReady,
    input  logic [1:0]             bResp
);
    import lsuBusPkg::*;

    axiStateType state;
    axiRespType  respCode;
    logic        awDone;
    logic        wDone;
    logic        awFinished;
    logic        wFinished;

    // aw and w may complete in either order
    assign awFinished = awDone || (awValid && awReady);
    assign wFinished  = wDone || (wValid && wReady);

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= busIdle;
            awDone       <= 1'b0;
            wDone        <= 1'b0;
            bus.respDone <= 1'b0;
        end else begin
            bus.respDone <= 1'b0;
            case (state)
                busIdle: if (bus.reqValid) state <= busAddr;
                busAddr: begin
                    if (!bus.write) begin
                        if (arReady) state <= busData;
                    end else if (awFinished && wFinished) begin
                        awDone <= 1'b0;
                        wDone  <= 1'b0;
                        state  <= busResp;
                    end else begin
                        awDone <= awFinished;
                        wDone  <= wFinished;
                    end
                end
                busData: begin
                    if (rValid) begin
                        bus.respDone <= 1'b1;
                        state        <= busIdle;
                    end
                end
                busResp: begin
                    if (bValid) begin
                        bus.respDone <= 1'b1;
                        state        <= busIdle;
                    end
                end
                default: state <= busIdle;
            endcase
        end
    end

    // response payload, captured as the handshake completes
    always_ff @(posedge clock) begin
        if (state == busData && rValid) begin
            bus.rdata <= rData;
            respCode  <= axiRespType'(rResp);
        end else if (state == busResp && bValid) begin
            respCode  <= axiRespType'(bResp);
        end
    end

    assign bus.respErr = respCode != OKAY;

    // the controller holds address and data stable for the whole access
    assign arValid = state == busAddr && !bus.write;
    assign awValid = state == busAddr && bus.write && !awDone;
    assign wValid  = state == busAddr && bus.write && !wDone;
    assign rReady  = state == busData;
    assign bReady  = state == busResp;
    assign arAddr  = bus.addr;
    assign awAddr  = bus.addr;
    assign wData   = bus.wdata;
    assign wStrb   = bus.wmask;

    assert property (@(posedge clock) disable iff (reset)
        arValid && !arReady |=> arValid);

endmodule

//--- src/clintTimer.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module clintTimer (
    input  logic    clock,
    input  logic    reset,
    memReqIf.target bus,
    output logic    timerIrq
);
    localparam int PRESCALE_W = $clog2(`LSU_TICK_DIV);

    logic [PRESCALE_W-1:0]  prescale;
    logic                   tick;
    logic [`LSU_DATA_W-1:0] mtime;
    logic [`LSU_DATA_W-1:0] mtimecmp;
    logic [15:0]            offset;

    function automatic logic [`LSU_DATA_W-1:0] mergeBytes(
        input logic [`LSU_DATA_W-1:0] oldWord,
        input logic [`LSU_DATA_W-1:0] newWord,
        input logic [`LSU_MASK_W-1:0] mask
    );
        logic [`LSU_DATA_W-1:0] merged;
        merged = oldWord;
        for (int i = 0; i < `LSU_MASK_W; i++) begin
            if (mask[i]) merged[i*8 +: 8] = newWord[i*8 +: 8];
        end
        return merged;
    endfunction

    assign offset = bus.addr[15:0];
    assign tick   = prescale == PRESCALE_W'(`LSU_TICK_DIV - 1);

    always_ff @(posedge clock) begin
        if (reset) begin
            prescale     <= '0;
            mtime        <= '0;
            mtimecmp     <= '1;
            timerIrq     <= 1'b0;
            bus.respDone <= 1'b0;
        end else begin
            prescale <= tick ? '0 : prescale + 1'b1;
            if (tick) mtime <= mtime + 1'b1;
            // a software write overrides the tick in the same cycle
            if (bus.reqValid && bus.write) begin
                if (offset == `LSU_MTIME_OFF) mtime <= mergeBytes(mtime, bus.wdata, bus.wmask);
                if (offset == `LSU_MTIMECMP_OFF) begin
                    mtimecmp <= mergeBytes(mtimecmp, bus.wdata, bus.wmask);
                end
            end
            timerIrq     <= mtime >= mtimecmp;
            bus.respDone <= bus.reqValid;
        end
    end

    always_ff @(posedge clock) begin
        if (bus.reqValid) begin
            case (offset)
                `LSU_MTIME_OFF:    bus.rdata <= mtime;
                `LSU_MTIMECMP_OFF: bus.rdata <= mtimecmp;
                default:           bus.rdata <= '0;
            endcase
        end
    end

    assign bus.respErr = 1'b0;

    // fixed single-cycle answer, controller latency depends on it
    assert property (@(posedge clock) disable iff (reset)
        bus.respDone == $past(bus.reqValid));

endmodule

//--- src/loadExtend.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module loadExtend (
    input  logic [`LSU_DATA_W-1:0] loadWord,
    input  logic [2:0]             loadOffset,
    input  lsuOpPkg::funct3Type    loadFunc3,
    output logic [`LSU_DATA_W-1:0] wbData
);
    import lsuOpPkg::*;

    logic [`LSU_DATA_W-1:0] shifted;
    logic                   zeroExt;

    // addressed byte lane moved down to bit 0
    assign shifted = loadWord >> {loadOffset, 3'b000};
    assign zeroExt = isUnsigned(loadFunc3);

    always_comb begin
        case (accessSize(loadFunc3))
            sizeByte: begin
                wbData = {{56{shifted[7] && !zeroExt}}, shifted[7:0]};
            end
            sizeHalf: begin
                wbData = {{48{shifted[15] && !zeroExt}}, shifted[15:0]};
            end
            sizeWord: begin
                wbData = {{32{shifted[31] && !zeroExt}}, shifted[31:0]};
            end
            // LD is always aligned, whole word as is
            default: wbData = loadWord;
        endcase
    end

endmodule

//--- src/lsuBusPkg.sv
package lsuBusPkg;

    // AXI response codes as they appear on rResp/bResp
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axiRespType;

    // master channel sequencing
    typedef enum logic [1:0] {
        busIdle,
        busAddr,
        busData,
        busResp
    } axiStateType;

endpackage

//--- src/lsuControl.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsuControl (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   exValid,
    input  logic                   exRead,
    input  logic                   exWrite,
    input  lsuOpPkg::funct3Type    exFunc3,
    input  logic [`LSU_ADDR_W-1:0] exAddr,
    input  logic [`LSU_DATA_W-1:0] exWdata,
    input  logic [`LSU_MASK_W-1:0] exWmask,
    output logic                   exReady,
    output logic                   wbValid,
    input  logic                   wbReady,
    output logic [`LSU_DATA_W-1:0] loadWord,
    output lsuOpPkg::funct3Type    loadFunc3,
    output logic [2:0]             loadOffset,
    output logic                   wbSkipRef,
    output logic                   wbFault,
    memReqIf.controller            spadBus,
    memReqIf.controller            timerBus,
    memReqIf.controller            devBus
);
    import lsuOpPkg::*;

    typedef enum logic [1:0] {ctlIdle, ctlIssue, ctlWait, ctlHold} ctlStateType;

    ctlStateType            state;
    logic                   reqPulse;
    logic                   opWrite;
    logic [`LSU_ADDR_W-1:0] opAddr;
    logic [`LSU_DATA_W-1:0] opWdata;
    logic [`LSU_MASK_W-1:0] opWmask;
    funct3Type              opFunc3;
    regionType              opRegion;
    regionType              exRegion;
    logic                   respDone;
    logic [`LSU_DATA_W-1:0] respData;
    logic                   respErr;

    // scratchpad wins over the timer window, everything else is a device
    always_comb begin
        if (exAddr[31:28] == `LSU_PMEM_NIBBLE) begin
            exRegion = regionSpad;
        end else if (exAddr >= `LSU_CLINT_BASE && exAddr <= `LSU_CLINT_END) begin
            exRegion = regionTimer;
        end else begin
            exRegion = regionDevice;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= ctlIdle;
            reqPulse <= 1'b0;
        end else begin
            reqPulse <= 1'b0;
            case (state)
                ctlIdle: if (exValid) state <= ctlIssue;
                ctlIssue: begin
                    // request goes out as a registered one-cycle pulse
                    reqPulse <= 1'b1;
                    state    <= ctlWait;
                end
                ctlWait: if (respDone) state <= ctlHold;
                ctlHold: if (wbReady) state <= ctlIdle;
                default: state <= ctlIdle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == ctlIdle && exValid) begin
            opWrite   <= exWrite && !exRead;
            opAddr    <= exAddr;
            opWdata   <= exWdata;
            opWmask   <= exWmask;
            opFunc3   <= exFunc3;
            opRegion  <= exRegion;
            wbSkipRef <= exRegion == regionDevice;
        end
        if (state == ctlWait && respDone) begin
            loadWord <= respData;
            wbFault  <= respErr;
        end
    end

    // response from whichever target got the request
    always_comb begin
        case (opRegion)
            regionSpad: begin
                respDone = spadBus.respDone;
                respData = spadBus.rdata;
                respErr  = spadBus.respErr;
            end
            regionTimer: begin
                respDone = timerBus.respDone;
                respData = timerBus.rdata;
                respErr  = timerBus.respErr;
            end
            default: begin
                respDone = devBus.respDone;
                respData = devBus.rdata;
                respErr  = devBus.respErr;
            end
        endcase
    end

    assign spadBus.reqValid  = reqPulse && opRegion == regionSpad;
    assign timerBus.reqValid = reqPulse && opRegion == regionTimer;
    assign devBus.reqValid   = reqPulse && opRegion == regionDevice;

    assign spadBus.write  = opWrite;
    assign spadBus.addr   = opAddr;
    assign spadBus.wdata  = opWdata;
    assign spadBus.wmask  = opWmask;
    assign timerBus.write = opWrite;
    assign timerBus.addr  = opAddr;
    assign timerBus.wdata = opWdata;
    assign timerBus.wmask = opWmask;
    assign devBus.write   = opWrite;
    assign devBus.addr    = opAddr;
    assign devBus.wdata   = opWdata;
    assign devBus.wmask   = opWmask;

    assign exReady    = state == ctlIdle;
    assign wbValid    = state == ctlHold;
    assign loadFunc3  = opFunc3;
    assign loadOffset = opAddr[2:0];

    // only the decoded target ever sees a request
    assert property (@(posedge clock) disable iff (reset)
        $onehot0({spadBus.reqValid, timerBus.reqValid, devBus.reqValid}));

    // writeback result is held until taken
    assert property (@(posedge clock) disable iff (reset)
        wbValid && !wbReady |=> wbValid && $stable(loadWord));

endmodule

//--- src/lsuOpPkg.sv
package lsuOpPkg;

    // RV64 load/store func3, bit 2 marks the unsigned loads
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LD  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        LWU = 3'b110
    } funct3Type;

    typedef enum logic [1:0] {
        sizeByte, sizeHalf, sizeWord, sizeDouble
    } accessSizeType;

    typedef enum logic [1:0] {
        regionSpad, regionTimer, regionDevice
    } regionType;

    // size part of func3
    function automatic accessSizeType accessSize(funct3Type f3);
        return accessSizeType'(f3[1:0]);
    endfunction

    function automatic logic isUnsigned(funct3Type f3);
        return f3[2];
    endfunction

endpackage

//--- src/lsuTop.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsuTop (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   exValid,
    output logic                   exReady,
    input  logic                   exRead,
    input  logic                   exWrite,
    input  lsuOpPkg::funct3Type    exFunc3,
    input  logic [`LSU_ADDR_W-1:0] exAddr,
    input  logic [`LSU_DATA_W-1:0] exWdata,
    input  logic [`LSU_MASK_W-1:0] exWmask,
    output logic                   wbValid,
    input  logic                   wbReady,
    output logic [`LSU_DATA_W-1:0] wbData,
    output logic                   wbSkipRef,
    output logic                   wbFault,
    output logic                   arValid,
    input  logic                   arReady,
    output logic [`LSU_ADDR_W-1:0] arAddr,
    input  logic                   rValid,
    output logic                   rReady,
    input  logic [`LSU_DATA_W-1:0] rData,
    input  logic [1:0]             rResp,
    output logic                   awValid,
    input  logic                   awReady,
    output logic [`LSU_ADDR_W-1:0] awAddr,
    output logic                   wValid,
    input  logic                   wReady,
    output logic [`LSU_DATA_W-1:0] wData,
    output logic [`LSU_MASK_W-1:0] wStrb,
    input  logic                   bValid,
    output logic                   bReady,
    input  logic [1:0]             bResp,
    output logic                   timerIrq
);
    logic [`LSU_DATA_W-1:0] loadWord;
    lsuOpPkg::funct3Type    loadFunc3;
    logic [2:0]             loadOffset;

    memReqIf spadBus ();
    memReqIf timerBus ();
    memReqIf devBus ();

    lsuControl control (
        .clock(clock), .reset(reset),
        .exValid(exValid), .exRead(exRead), .exWrite(exWrite), .exFunc3(exFunc3),
        .exAddr(exAddr), .exWdata(exWdata), .exWmask(exWmask), .exReady(exReady),
        .wbValid(wbValid), .wbReady(wbReady),
        .loadWord(loadWord), .loadFunc3(loadFunc3), .loadOffset(loadOffset),
        .wbSkipRef(wbSkipRef), .wbFault(wbFault),
        .spadBus(spadBus.controller), .timerBus(timerBus.controller),
        .devBus(devBus.controller)
    );

    scratchpadMem spad (.clock(clock), .reset(reset), .bus(spadBus.target));

    clintTimer timer (.clock(clock), .reset(reset), .bus(timerBus.target), .timerIrq(timerIrq));

    axiLiteMaster axiMaster (
        .clock(clock), .reset(reset), .bus(devBus.target),
        .arValid(arValid), .arReady(arReady), .arAddr(arAddr),
        .rValid(rValid), .rReady(rReady), .rData(rData), .rResp(rResp),
        .awValid(awValid), .awReady(awReady), .awAddr(awAddr),
        .wValid(wValid), .wReady(wReady), .wData(wData), .wStrb(wStrb),
        .bValid(bValid), .bReady(bReady), .bResp(bResp)
    );

    loadExtend extend (
        .loadWord(loadWord), .loadOffset(loadOffset), .loadFunc3(loadFunc3),
        .wbData(wbData)
    );

endmodule

//--- src/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// bus widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 64
`define LSU_MASK_W (`LSU_DATA_W / 8)

// region map, scratchpad picked by addr[31:28]
`define LSU_PMEM_NIBBLE 4'h8
`define LSU_CLINT_BASE 32'h0200_0000
`define LSU_CLINT_END 32'h0200_FFFF

// timer register offsets inside the window
`define LSU_MTIMECMP_OFF 16'h4000
`define LSU_MTIME_OFF 16'hBFF8

`define LSU_SPAD_WORDS 256
`define LSU_TICK_DIV 4

`endif

//--- src/memReqIf.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

interface memReqIf;

    // request side, held stable by the controller until the next operation
    logic                   reqValid;
    logic                   write;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] wdata;
    logic [`LSU_MASK_W-1:0] wmask;

    // response side, only meaningful while respDone is high
    logic                   respDone;
    logic [`LSU_DATA_W-1:0] rdata;
    logic                   respErr;

    modport controller (
        output reqValid, write, addr, wdata, wmask,
        input  respDone, rdata, respErr
    );

    modport target (
        input  reqValid, write, addr, wdata, wmask,
        output respDone, rdata, respErr
    );

endinterface

//--- src/scratchpadMem.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module scratchpadMem (
    input  logic    clock,
    input  logic    reset,
    memReqIf.target bus
);
    localparam int IDX_W = $clog2(`LSU_SPAD_WORDS);

    logic [`LSU_DATA_W-1:0] mem [`LSU_SPAD_WORDS];
    logic [IDX_W-1:0]       index;

    // word index, the low three bits pick a byte lane
    assign index = bus.addr[IDX_W+2:3];

    always_ff @(posedge clock) begin
        if (bus.reqValid) begin
            if (bus.write) begin
                for (int i = 0; i < `LSU_MASK_W; i++) begin
                    if (bus.wmask[i]) mem[index][i*8 +: 8] <= bus.wdata[i*8 +: 8];
                end
            end
            // read-before-write on a store, the value is unused then
            bus.rdata <= mem[index];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bus.respDone <= 1'b0;
        end else begin
            bus.respDone <= bus.reqValid;
        end
    end

    assign bus.respErr = 1'b0;

endmodule

//--- verif/axiDeviceModel.sv
`timescale 1ns/1ps

module axiDeviceModel (
    input  logic        clock,
    input  logic        reset,
    input  logic        arValid,
    output logic        arReady,
    input  logic [31:0] arAddr,
    output logic        rValid,
    input  logic        rReady,
    output logic [63:0] rData,
    output logic [1:0]  rResp,
    input  logic        awValid,
    output logic        awReady,
    input  logic [31:0] awAddr,
    input  logic        wValid,
    output logic        wReady,
    input  logic [63:0] wData,
    input  logic [7:0]  wStrb,
    output logic        bValid,
    input  logic        bReady,
    output logic [1:0]  bResp
);
    integer      seed = 41;
    logic [31:0] memAddr [$];
    logic [63:0] memData [$];

    function automatic int readyDelay();
        return $unsigned($random(seed)) % 4;
    endfunction

    function automatic logic inErrorWindow(input logic [31:0] addr);
        return addr >= 32'h4000_0000 && addr <= 32'h4000_0FFF;
    endfunction

    function automatic logic [63:0] readWord(input logic [31:0] addr);
        for (int i = 0; i < memAddr.size(); i++) begin
            if (memAddr[i] == addr) return memData[i];
        end
        // untouched words read back a pattern built from the address
        return {addr ^ 32'hA5A5_A5A5, addr};
    endfunction

    task automatic writeWord(input logic [31:0] addr, input logic [63:0] data,
                             input logic [7:0] strb);
        logic [63:0] word;
        int          found;
        word = readWord(addr);
        for (int i = 0; i < 8; i++) begin
            if (strb[i]) word[i*8 +: 8] = data[i*8 +: 8];
        end
        found = -1;
        for (int i = 0; i < memAddr.size(); i++) begin
            if (memAddr[i] == addr) found = i;
        end
        if (found < 0) begin
            memAddr.push_back(addr);
            memData.push_back(word);
        end else begin
            memData[found] = word;
        end
    endtask

    // ready goes up on a falling edge, so the rising edge after it completes the transfer
    task automatic serveRead();
        logic [31:0] addr;
        repeat (readyDelay()) @(negedge clock);
        addr = {arAddr[31:3], 3'b000};
        arReady = 1'b1;
        @(negedge clock);
        arReady = 1'b0;
        repeat (readyDelay()) @(negedge clock);
        if (inErrorWindow(addr)) begin
            rData = '0;
            rResp = 2'b10;
        end else begin
            rData = readWord(addr);
            rResp = 2'b00;
        end
        rValid = 1'b1;
        while (!rReady) @(negedge clock);
        @(negedge clock);
        rValid = 1'b0;
    endtask

    task automatic serveWrite();
        logic [31:0] addr;
        logic [63:0] data;
        logic [7:0]  strb;
        // address and data channels finish independently
        fork
            begin
                repeat (readyDelay()) @(negedge clock);
                addr = {awAddr[31:3], 3'b000};
                awReady = 1'b1;
                @(negedge clock);
                awReady = 1'b0;
            end
            begin
                repeat (readyDelay()) @(negedge clock);
                data = wData;
                strb = wStrb;
                wReady = 1'b1;
                @(negedge clock);
                wReady = 1'b0;
            end
        join
        repeat (readyDelay()) @(negedge clock);
        if (inErrorWindow(addr)) begin
            bResp = 2'b10;
        end else begin
            bResp = 2'b00;
            writeWord(addr, data, strb);
        end
        bValid = 1'b1;
        while (!bReady) @(negedge clock);
        @(negedge clock);
        bValid = 1'b0;
    endtask

    initial begin
        arReady = 1'b0;
        rValid  = 1'b0;
        rData   = '0;
        rResp   = 2'b00;
        awReady = 1'b0;
        wReady  = 1'b0;
        bValid  = 1'b0;
        bResp   = 2'b00;
        forever begin
            @(negedge clock);
            if (reset === 1'b0 && arValid === 1'b1) begin
                serveRead();
            end else if (reset === 1'b0 && awValid === 1'b1) begin
                serveWrite();
            end
        end
    end

endmodule

//--- verif/lsuPatterns.txt
# name kind func3 address storeData mask expectedLoad flags(bit1 skipRef, bit0 fault)
# kinds: S store, L load, B load under back-pressure, G mtime grows, I wait for timerIrq
spStoreW0   S 3 80000000 f0e1d2c3b4a59687 ff 0 0
spStoreW1   S 3 80000008 0123456789abcdef ff 0 0
spStoreLane S 3 80000008 0000000000007f00 02 0 0
spStoreTop  S 3 800007f8 8000000000000001 ff 0 0
spLbNeg     L 0 80000000 0 00 ffffffffffffff87 0
spLbuOff1   L 4 80000001 0 00 0000000000000096 0
spLbOff7    L 0 80000007 0 00 fffffffffffffff0 0
spLhOff2    L 1 80000002 0 00 ffffffffffffb4a5 0
spLhuOff6   L 5 80000006 0 00 000000000000f0e1 0
spLwOff0    L 2 80000000 0 00 ffffffffb4a59687 0
spLwuOff4   L 6 80000004 0 00 00000000f0e1d2c3 0
spLdW0      L 3 80000000 0 00 f0e1d2c3b4a59687 0
spLbLane1   L 0 80000009 0 00 000000000000007f 0
spLhMerged  L 1 80000008 0 00 0000000000007fef 0
spLwPos     L 2 8000000c 0 00 0000000001234567 0
spLdMerged  L 3 80000008 0 00 0123456789ab7fef 0
spLwTop     L 2 800007fc 0 00 ffffffff80000000 0
spLbuTop    L 4 800007f8 0 00 0000000000000001 0
devStoreA   S 3 10000000 1122334455667788 ff 0 2
devStoreHi  S 3 10000010 cafebabe00000000 f0 0 2
devLdA      L 3 10000000 0 00 1122334455667788 2
devLbuA     L 4 10000003 0 00 0000000000000055 2
devLdMerged L 3 10000010 0 00 cafebabe10000010 2
devLwHi     L 2 10000014 0 00 ffffffffcafebabe 2
devErrLoad  L 3 40000100 0 00 0000000000000000 3
devErrStore S 3 40000ff8 1234 ff 0 3
tmCmpWrite  S 3 02004000 00000000deadbeef ff 0 0
tmCmpRead   L 3 02004000 0 00 00000000deadbeef 0
tmUnknown   L 3 02000100 0 00 0000000000000000 0
tmTimeGrows G 3 0200bff8 10 00 0 0
tmCmpSmall  S 3 02004000 10 ff 0 0
tmIrqHigh   I 0 0 200 00 1 0
tmCmpMax    S 3 02004000 ffffffffffffffff ff 0 0
tmIrqLow    I 0 0 10 00 0 0
bpSpadLd    B 3 80000000 0 00 f0e1d2c3b4a59687 0
bpDevLd     B 3 10000000 0 00 1122334455667788 2
bpSpadLh    B 1 80000002 0 00 ffffffffffffb4a5 0
bpDevLw     B 2 10000014 0 00 ffffffffcafebabe 2

//--- verif/lsuTb.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsuTb;
    import lsuOpPkg::*;

    typedef struct packed {
        logic [7:0]  kind;
        logic [2:0]  func3;
        logic [31:0] addr;
        logic [63:0] data;
        logic [7:0]  mask;
        logic [63:0] expVal;
        logic [1:0]  expFlags;
    } patternType;

    logic                   clock;
    logic                   reset;
    logic                   exValid;
    logic                   exReady;
    logic                   exRead;
    logic                   exWrite;
    funct3Type              exFunc3;
    logic [`LSU_ADDR_W-1:0] exAddr;
    logic [`LSU_DATA_W-1:0] exWdata;
    logic [`LSU_MASK_W-1:0] exWmask;
    logic                   wbValid;
    logic                   wbReady;
    logic [`LSU_DATA_W-1:0] wbData;
    logic                   wbSkipRef;
    logic                   wbFault;
    logic                   arValid, arReady, rValid, rReady;
    logic                   awValid, awReady, wValid, wReady, bValid, bReady;
    logic [`LSU_ADDR_W-1:0] arAddr, awAddr;
    logic [`LSU_DATA_W-1:0] rData, wData;
    logic [`LSU_MASK_W-1:0] wStrb;
    logic [1:0]             rResp, bResp;
    logic                   timerIrq;

    integer     seed = 41;
    int         errors = 0;
    int         checks = 0;
    int         numPatterns = 0;
    logic       loaded = 1'b0;
    patternType patterns [$];
    string      names [$];

    lsuTop uut (.*);

    axiDeviceModel device (.*);

    always #50 clock = ~clock;

    task automatic checkValue(input string name, input string what,
                              input logic [63:0] expected, input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR %s %s expected %h actual %h", name, what, expected, actual);
        end
    endtask

    task automatic checkTrue(input string name, input logic ok, input string message);
        checks++;
        assert (ok === 1'b1) else begin
            errors++;
            $display("%s in test %s", message, name);
        end
    endtask

    function automatic logic isDevice(input logic [31:0] addr);
        return addr[31:28] != `LSU_PMEM_NIBBLE &&
               !(addr >= `LSU_CLINT_BASE && addr <= `LSU_CLINT_END);
    endfunction

    // one operation, entered and left on a falling edge with the stage idle
    task automatic runOp(input string name, input patternType p, input logic stall,
                         output logic [63:0] result);
        int latency;
        int span;
        checkTrue(name, exReady, "exReady low when an operation was offered");
        exValid = 1'b1;
        exRead  = p.kind != "S";
        exWrite = p.kind == "S";
        exFunc3 = funct3Type'(p.func3);
        exAddr  = p.addr;
        exWdata = p.data;
        exWmask = p.mask;
        wbReady = !stall;
        // accepted on the coming rising edge
        @(negedge clock);
        exValid = 1'b0;
        latency = 0;
        while (!wbValid) begin
            latency++;
            @(negedge clock);
        end
        result = wbData;
        checkValue(name, "flags", p.expFlags, {wbSkipRef, wbFault});
        if (!isDevice(p.addr)) checkValue(name, "latency", 3, latency);
        if (stall) begin
            span = 1 + $unsigned($random(seed)) % 4;
            repeat (span) begin
                @(negedge clock);
                checkTrue(name, wbValid && wbData === result && !exReady,
                          "result not held under back-pressure");
            end
            wbReady = 1'b1;
        end
        @(negedge clock);
        checkTrue(name, !wbValid, "result presented a second time");
    endtask

    initial begin
        int          fd;
        int          fields;
        int          waited;
        string       line;
        string       name;
        string       kind;
        logic [2:0]  func3;
        logic [31:0] addr;
        logic [63:0] data;
        logic [7:0]  mask;
        logic [63:0] expVal;
        logic [1:0]  expFlags;
        patternType  p;
        logic [63:0] result;
        logic [63:0] first;

        clock   = 1'b0;
        reset   = 1'b1;
        exValid = 1'b0;
        exRead  = 1'b0;
        exWrite = 1'b0;
        exFunc3 = LD;
        exAddr  = '0;
        exWdata = '0;
        exWmask = '0;
        wbReady = 1'b1;

        fd = $fopen("verif/lsuPatterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open verif/lsuPatterns.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                // blank and # lines carry no operation
                if (line.len() > 1 && line[0] != "#") begin
                    fields = $sscanf(line, "%s %s %h %h %h %h %h %h", name, kind,
                                     func3, addr, data, mask, expVal, expFlags);
                    if (fields == 8) begin
                        p = {kind[0], func3, addr, data, mask, expVal, expFlags};
                        patterns.push_back(p);
                        names.push_back(name);
                    end else begin
                        errors++;
                        $display("malformed pattern line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        numPatterns = patterns.size();
        if (numPatterns == 0) begin
            errors++;
            $display("no patterns were read");
        end
        loaded = 1'b1;

        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        checkTrue("reset", exReady && !wbValid && !arValid && !awValid && !wValid &&
                  !rReady && !bReady && !timerIrq, "outputs not at their reset values");

        for (int i = 0; i < numPatterns; i++) begin
            p = patterns[i];
            case (p.kind)
                "S": runOp(names[i], p, 1'b0, result);
                "L", "B": begin
                    runOp(names[i], p, p.kind == "B", result);
                    checkValue(names[i], "load", p.expVal, result);
                end
                "G": begin
                    runOp(names[i], p, 1'b0, first);
                    repeat (p.data) @(negedge clock);
                    runOp(names[i], p, 1'b0, result);
                    checkTrue(names[i], result > first, "mtime did not advance");
                end
                "I": begin
                    waited = 0;
                    while (timerIrq !== p.expVal[0] && waited < p.data) begin
                        @(negedge clock);
                        waited++;
                    end
                    checkTrue(names[i], timerIrq === p.expVal[0],
                              "timerIrq did not reach the expected level");
                end
                default: checkTrue(names[i], 1'b0, "unknown pattern kind");
            endcase
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // budget grows with the pattern count
    initial begin
        wait (loaded);
        repeat (numPatterns * 200 + 16) @(posedge clock);
        $display("watchdog expired after %0d cycles", numPatterns * 200 + 16);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
